//--- source/exec_pkg.sv
// Shared widths, operation encoding and compare flags for the execute stage, used by scoped name
package exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Data and address width
    localparam int XLEN              = 32;
    // Default instruction tag width
    localparam int TAG_WIDTH_DEFAULT = 3;
    localparam int BYTES_PER_WORD    = 4;
    // Low operand bits taken as shift amount
    localparam int SHAMT_WIDTH       = 5;
    // Link increment for JAL/JALR
    localparam int INSTR_BYTES       = 4;

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    ////////////////////////////////////////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        // Arithmetic and logic
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        LUI,
        // Unconditional jumps
        JAL,
        JALR,
        // Conditional branches
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        // Loads
        LB,
        LBU,
        LH,
        LHU,
        LW,
        // Stores
        SB,
        SH,
        SW
    } exec_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Compare flags
    ////////////////////////////////////////////////////////////////////////////

    // First operand against second operand
    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
        logic ge;
        logic geu;
    } cmp_flags_t;

endpackage

//--- source/exec_operand_if.sv
// Decoded operation and operand bundle, driven by the top level and read by the execute units
interface exec_operand_if;

    // Valid every cycle, no handshake
    exec_pkg::exec_op_e op;
    exec_pkg::word_t    first_operand;
    exec_pkg::word_t    second_operand;
    exec_pkg::word_t    third_operand;
    exec_pkg::word_t    pc;

    // ALU sees the whole instruction
    modport alu (
        input op,
        input first_operand,
        input second_operand,
        input third_operand,
        input pc
    );

    // Branch offset lives in the third operand
    modport branch (
        input op,
        input third_operand,
        input pc
    );

    // Store data lives in the third operand
    modport lsu (
        input op,
        input third_operand
    );

endinterface

//--- source/exec_alu.sv
// Execute stage ALU: arithmetic, logic, shifts and compares with the registered write-back result
module exec_alu (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    exec_operand_if.alu            ops,
    input  logic                   killed_i,
    output exec_pkg::word_t        sum_o,
    output exec_pkg::cmp_flags_t   cmp_o,
    output logic                   write_enable_o,
    output exec_pkg::exec_op_e     op_o,
    output exec_pkg::word_t        result_o
);

    logic [exec_pkg::SHAMT_WIDTH-1:0] shamt;
    exec_pkg::word_t                  sum2_a;
    exec_pkg::word_t                  sum2_b;
    exec_pkg::word_t                  sum2;
    exec_pkg::word_t                  result;
    logic                             write_enable;

    assign shamt = ops.second_operand[exec_pkg::SHAMT_WIDTH-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Adders
    ////////////////////////////////////////////////////////////////////////////

    assign sum_o = ops.first_operand + ops.second_operand;

    // Second adder covers SUB and the pc-relative link value
    always_comb begin
        if (ops.op == exec_pkg::SUB) begin
            sum2_a = ops.first_operand;
            sum2_b = -ops.second_operand;
        end
        else begin
            sum2_a = ops.pc;
            sum2_b = exec_pkg::word_t'(exec_pkg::INSTR_BYTES);
        end
    end

    assign sum2 = sum2_a + sum2_b;

    ////////////////////////////////////////////////////////////////////////////
    // Compare flags
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        cmp_o.eq  = ops.first_operand == ops.second_operand;
        cmp_o.lt  = $signed(ops.first_operand) < $signed(ops.second_operand);
        cmp_o.ltu = ops.first_operand < ops.second_operand;
        cmp_o.ge  = $signed(ops.first_operand) >= $signed(ops.second_operand);
        cmp_o.geu = ops.first_operand >= ops.second_operand;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (ops.op)
            exec_pkg::SUB,
            exec_pkg::JAL,
            exec_pkg::JALR: result = sum2;
            exec_pkg::SLT:  result = {{(exec_pkg::XLEN-1){1'b0}}, cmp_o.lt};
            exec_pkg::SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, cmp_o.ltu};
            exec_pkg::XOR:  result = ops.first_operand ^ ops.second_operand;
            exec_pkg::OR:   result = ops.first_operand | ops.second_operand;
            exec_pkg::AND:  result = ops.first_operand & ops.second_operand;
            exec_pkg::SLL:  result = ops.first_operand << shamt;
            exec_pkg::SRL:  result = ops.first_operand >> shamt;
            exec_pkg::SRA:  result = $signed(ops.first_operand) >>> shamt;
            exec_pkg::LUI:  result = ops.second_operand;
            // Loads and the rest take the plain sum
            default:        result = sum_o;
        endcase
    end

    // Stores and branches never write back
    always_comb begin
        if (ops.op inside {exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
                           exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                           exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU}) begin
            write_enable = 1'b0;
        end
        else begin
            write_enable = ~killed_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
        end
        else if (!stall_i) begin
            write_enable_o <= write_enable;
        end
    end

    // Payload held under stall
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            op_o     <= ops.op;
            result_o <= result;
        end
    end

    a_no_wb_on_store_branch: assert property (@(posedge clk) disable iff (reset)
        (!stall_i && ops.op inside {exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
                                    exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                                    exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU})
        |=> !write_enable_o)
        else $error("write enable raised for a store or branch");

endmodule

//--- source/exec_branch.sv
// Execute stage branch unit: branch decision, jump target, current tag and kill generation
module exec_branch #(
    parameter int TAG_WIDTH = exec_pkg::TAG_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,
    exec_operand_if.branch         ops,
    input  exec_pkg::word_t        sum_i,
    input  exec_pkg::cmp_flags_t   cmp_i,
    input  logic [TAG_WIDTH-1:0]   tag_i,
    output logic                   killed_o,
    output logic                   jump_o,
    output exec_pkg::word_t        jump_target_o
);

    logic [TAG_WIDTH-1:0] curr_tag;
    logic                 taken;

    ////////////////////////////////////////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (ops.op)
            exec_pkg::BEQ:  taken = cmp_i.eq;
            exec_pkg::BNE:  taken = ~cmp_i.eq;
            exec_pkg::BLT:  taken = cmp_i.lt;
            exec_pkg::BLTU: taken = cmp_i.ltu;
            exec_pkg::BGE:  taken = cmp_i.ge;
            exec_pkg::BGEU: taken = cmp_i.geu;
            exec_pkg::JAL,
            exec_pkg::JALR: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    // A killed instruction never redirects the fetch
    assign jump_o = taken & ~killed_o;

    // JALR clears bit 0, conditional branches are pc relative
    always_comb begin
        unique case (ops.op)
            exec_pkg::JALR: jump_target_o = {sum_i[exec_pkg::XLEN-1:1], 1'b0};
            exec_pkg::JAL:  jump_target_o = sum_i;
            default:        jump_target_o = ops.pc + ops.third_operand;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tag control
    ////////////////////////////////////////////////////////////////////////////

    // Each jump opens a new flow, wraps at 2**TAG_WIDTH
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end
        else if (jump_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    assign killed_o = curr_tag != tag_i;

    a_killed_keeps_tag: assert property (@(posedge clk) disable iff (reset)
        killed_o |=> $stable(curr_tag))
        else $error("tag advanced by a killed instruction");

endmodule

//--- source/exec_lsu.sv
// Execute stage load/store formatting: word address, read enable, byte enables and store data
module exec_lsu (
    exec_operand_if.lsu          ops,
    input  exec_pkg::word_t      sum_i,
    output exec_pkg::word_t      mem_address_o,
    output logic                 mem_read_enable_o,
    output exec_pkg::byte_en_t   mem_write_enable_o,
    output exec_pkg::word_t      mem_write_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Address and read enable
    ////////////////////////////////////////////////////////////////////////////

    // Word aligned, lane select stays in the byte enables
    assign mem_address_o = {sum_i[exec_pkg::XLEN-1:2], 2'b00};

    assign mem_read_enable_o = ops.op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
                                              exec_pkg::LHU, exec_pkg::LW};

    ////////////////////////////////////////////////////////////////////////////
    // Store lanes and data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (ops.op)
            exec_pkg::SB: begin
                unique case (sum_i[1:0])
                    2'b00:   mem_write_enable_o = 4'b0001;
                    2'b01:   mem_write_enable_o = 4'b0010;
                    2'b10:   mem_write_enable_o = 4'b0100;
                    default: mem_write_enable_o = 4'b1000;
                endcase
            end
            // Half select by address bit 1
            exec_pkg::SH: mem_write_enable_o = sum_i[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: mem_write_enable_o = 4'b1111;
            default:      mem_write_enable_o = 4'b0000;
        endcase
    end

    // Replicated so the enabled lanes see the right bytes
    always_comb begin
        unique case (ops.op)
            exec_pkg::SB: mem_write_data_o = {4{ops.third_operand[7:0]}};
            exec_pkg::SH: mem_write_data_o = {2{ops.third_operand[15:0]}};
            default:      mem_write_data_o = ops.third_operand;
        endcase
    end

endmodule

//--- source/execute_top.sv
// Execute stage top level: plain ports onto the operand bundle, feeding ALU, branch and LSU units
module execute_top #(
    parameter int TAG_WIDTH = exec_pkg::TAG_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall_i,
    input  logic [TAG_WIDTH-1:0]   tag_i,
    input  exec_pkg::exec_op_e     op_i,
    input  exec_pkg::word_t        first_operand_i,
    input  exec_pkg::word_t        second_operand_i,
    input  exec_pkg::word_t        third_operand_i,
    input  exec_pkg::word_t        pc_i,

    output logic                   killed_o,
    output logic                   jump_o,
    output exec_pkg::word_t        jump_target_o,

    output logic                   write_enable_o,
    output exec_pkg::exec_op_e     op_o,
    output exec_pkg::word_t        result_o,

    output exec_pkg::word_t        mem_address_o,
    output logic                   mem_read_enable_o,
    output exec_pkg::byte_en_t     mem_write_enable_o,
    output exec_pkg::word_t        mem_write_data_o
);

    exec_pkg::word_t      sum;
    exec_pkg::cmp_flags_t cmp;

    exec_operand_if ops ();

    assign ops.op             = op_i;
    assign ops.first_operand  = first_operand_i;
    assign ops.second_operand = second_operand_i;
    assign ops.third_operand  = third_operand_i;
    assign ops.pc             = pc_i;

    exec_alu u_alu (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .ops            (ops),
        .killed_i       (killed_o),
        .sum_o          (sum),
        .cmp_o          (cmp),
        .write_enable_o (write_enable_o),
        .op_o           (op_o),
        .result_o       (result_o)
    );

    exec_branch #(
        .TAG_WIDTH (TAG_WIDTH)
    ) u_branch (
        .clk           (clk),
        .reset         (reset),
        .ops           (ops),
        .sum_i         (sum),
        .cmp_i         (cmp),
        .tag_i         (tag_i),
        .killed_o      (killed_o),
        .jump_o        (jump_o),
        .jump_target_o (jump_target_o)
    );

    exec_lsu u_lsu (
        .ops                (ops),
        .sum_i              (sum),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

endmodule

//--- dv/exec_tb_pkg.sv
// Testbench package for the execute stage: stimulus table builder and expected-value model
package exec_tb_pkg;

    localparam int TAG_WIDTH = exec_pkg::TAG_WIDTH_DEFAULT;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // One table row, inputs first, then the expected responses
    typedef struct packed {
        exec_pkg::exec_op_e op;
        exec_pkg::word_t    first;
        exec_pkg::word_t    second;
        exec_pkg::word_t    third;
        exec_pkg::word_t    pc;
        tag_t               tag;
        logic               stall;
        logic               killed;
        logic               jump;
        exec_pkg::word_t    target;
        exec_pkg::word_t    address;
        logic               read_en;
        exec_pkg::byte_en_t write_en;
        exec_pkg::word_t    write_data;
        // Registered outputs seen one cycle later
        logic               we;
        exec_pkg::exec_op_e op_out;
        exec_pkg::word_t    result;
    } row_t;

    // Current tag and the held output register
    typedef struct packed {
        tag_t               tag;
        logic               we;
        exec_pkg::exec_op_e op;
        exec_pkg::word_t    result;
    } model_t;

    function automatic exec_pkg::word_t random_word(inout integer seed);
        return $random(seed);
    endfunction

    function automatic logic is_load(exec_pkg::exec_op_e op);
        return op inside {exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH, exec_pkg::LHU, exec_pkg::LW};
    endfunction

    function automatic logic is_store(exec_pkg::exec_op_e op);
        return op inside {exec_pkg::SB, exec_pkg::SH, exec_pkg::SW};
    endfunction

    function automatic logic is_branch(exec_pkg::exec_op_e op);
        return op inside {exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                          exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU};
    endfunction

    function automatic logic is_control(exec_pkg::exec_op_e op);
        return is_branch(op) || op == exec_pkg::JAL || op == exec_pkg::JALR;
    endfunction

    function automatic logic expect_taken(exec_pkg::exec_op_e op, exec_pkg::word_t a,
                                          exec_pkg::word_t b);
        case (op)
            exec_pkg::BEQ:  return a == b;
            exec_pkg::BNE:  return a != b;
            exec_pkg::BLT:  return $signed(a) < $signed(b);
            exec_pkg::BLTU: return a < b;
            exec_pkg::BGE:  return $signed(a) >= $signed(b);
            exec_pkg::BGEU: return a >= b;
            exec_pkg::JAL,
            exec_pkg::JALR: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    function automatic exec_pkg::word_t expect_result(exec_pkg::exec_op_e op,
                                                      exec_pkg::word_t a, exec_pkg::word_t b,
                                                      exec_pkg::word_t pc);
        logic [exec_pkg::SHAMT_WIDTH-1:0] amount;
        amount = b[exec_pkg::SHAMT_WIDTH-1:0];
        case (op)
            exec_pkg::SUB:  return a - b;
            exec_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::XOR:  return a ^ b;
            exec_pkg::OR:   return a | b;
            exec_pkg::AND:  return a & b;
            exec_pkg::SLL:  return a << amount;
            exec_pkg::SRL:  return a >> amount;
            exec_pkg::SRA:  return $signed(a) >>> amount;
            exec_pkg::LUI:  return b;
            exec_pkg::JAL,
            exec_pkg::JALR: return pc + exec_pkg::INSTR_BYTES;
            default:        return a + b;
        endcase
    endfunction

    function automatic exec_pkg::byte_en_t expect_byte_en(exec_pkg::exec_op_e op,
                                                          logic [1:0] low);
        case (op)
            exec_pkg::SB: return exec_pkg::byte_en_t'(1) << low;
            exec_pkg::SH: return low[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: return 4'b1111;
            default:      return 4'b0000;
        endcase
    endfunction

    // Computes the expected responses of one row and advances the model
    function automatic void add_row(ref row_t rows[$], inout model_t m,
                                    input exec_pkg::exec_op_e op, exec_pkg::word_t a,
                                    exec_pkg::word_t b, exec_pkg::word_t c, exec_pkg::word_t pc,
                                    tag_t tag, logic stall);
        row_t            r;
        exec_pkg::word_t sum;
        sum = a + b;
        r.op = op;
        r.first = a;
        r.second = b;
        r.third = c;
        r.pc = pc;
        r.tag = tag;
        r.stall = stall;
        r.killed = tag != m.tag;
        r.jump = expect_taken(op, a, b) && !r.killed;
        if (op == exec_pkg::JALR) begin
            r.target = sum & ~32'd1;
        end
        else if (op == exec_pkg::JAL) begin
            r.target = sum;
        end
        else begin
            r.target = pc + c;
        end
        r.address = sum & ~32'd3;
        r.read_en = is_load(op);
        r.write_en = expect_byte_en(op, sum[1:0]);
        case (op)
            exec_pkg::SB: r.write_data = {4{c[7:0]}};
            exec_pkg::SH: r.write_data = {2{c[15:0]}};
            default:      r.write_data = c;
        endcase
        if (!stall) begin
            m.we = !(is_store(op) || is_branch(op)) && !r.killed;
            m.op = op;
            m.result = expect_result(op, a, b, pc);
        end
        r.we = m.we;
        r.op_out = m.op;
        r.result = m.result;
        // Tag moves on every jump, stalled or not
        if (r.jump) begin
            m.tag = m.tag + 1'b1;
        end
        rows.push_back(r);
    endfunction

    function automatic void build_table(inout integer seed, ref row_t rows[$]);
        model_t             m;
        exec_pkg::exec_op_e op;
        exec_pkg::word_t    neg;
        exec_pkg::word_t    pos;
        tag_t               old_tag;
        int                 i;
        int                 k;
        // Matches the idle drive during reset
        m = '{tag: '0, we: 1'b0, op: exec_pkg::ADD, result: '0};

        // ALU operations, LUI and link values
        for (i = int'(exec_pkg::ADD); i <= int'(exec_pkg::JALR); i++) begin
            op = exec_pkg::exec_op_e'(i);
            add_row(rows, m, op, random_word(seed), random_word(seed), random_word(seed),
                    random_word(seed) & ~32'd3, m.tag, 1'b0);
            if (op != exec_pkg::JAL && op != exec_pkg::JALR) begin
                add_row(rows, m, op, random_word(seed), random_word(seed), random_word(seed),
                        random_word(seed) & ~32'd3, m.tag, 1'b0);
            end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Loads and stores
        ////////////////////////////////////////////////////////////////////////////

        for (i = int'(exec_pkg::LB); i <= int'(exec_pkg::LW); i++) begin
            add_row(rows, m, exec_pkg::exec_op_e'(i), random_word(seed), random_word(seed),
                    random_word(seed), random_word(seed) & ~32'd3, m.tag, 1'b0);
        end
        for (k = 0; k < 4; k++) begin
            add_row(rows, m, exec_pkg::SB, random_word(seed) & ~32'd3,
                    (random_word(seed) & ~32'd3) | k, random_word(seed), 32'h100, m.tag, 1'b0);
            add_row(rows, m, exec_pkg::SH, random_word(seed) & ~32'd3,
                    (random_word(seed) & ~32'd3) | k, random_word(seed), 32'h104, m.tag, 1'b0);
        end
        add_row(rows, m, exec_pkg::SW, random_word(seed), random_word(seed), random_word(seed),
                32'h108, m.tag, 1'b0);

        // Branches, one taken and one not taken each
        for (i = int'(exec_pkg::BEQ); i <= int'(exec_pkg::BGEU); i++) begin
            op = exec_pkg::exec_op_e'(i);
            neg = random_word(seed) | 32'h8000_0000;
            pos = random_word(seed) & 32'h7fff_ffff;
            if (op == exec_pkg::BEQ || op == exec_pkg::BNE) begin
                add_row(rows, m, op, neg, neg, random_word(seed) & ~32'd1, 32'h200, m.tag, 1'b0);
            end
            else begin
                add_row(rows, m, op, pos, neg, random_word(seed) & ~32'd1, 32'h200, m.tag, 1'b0);
            end
            add_row(rows, m, op, neg, pos, random_word(seed) & ~32'd1, 32'h204, m.tag, 1'b0);
        end

        ////////////////////////////////////////////////////////////////////////////
        // Kill and tag wrap
        ////////////////////////////////////////////////////////////////////////////

        old_tag = m.tag;
        add_row(rows, m, exec_pkg::JAL, 32'h300, 32'h40, 32'h0, 32'h300, m.tag, 1'b0);
        add_row(rows, m, exec_pkg::ADD, random_word(seed), random_word(seed), 32'h0,
                32'h304, old_tag, 1'b0);
        add_row(rows, m, exec_pkg::JAL, 32'h304, 32'h80, 32'h0, 32'h304, old_tag, 1'b0);
        add_row(rows, m, exec_pkg::ADD, random_word(seed), random_word(seed), 32'h0,
                32'h340, m.tag, 1'b0);
        for (k = 0; k < 2 ** TAG_WIDTH; k++) begin
            add_row(rows, m, exec_pkg::JAL, 32'h400 + 16 * k, 32'h10, 32'h0,
                    32'h400 + 16 * k, m.tag, 1'b0);
        end
        add_row(rows, m, exec_pkg::SUB, random_word(seed), random_word(seed), 32'h0,
                32'h500, m.tag, 1'b0);
        add_row(rows, m, exec_pkg::ADD, random_word(seed), random_word(seed), 32'h0,
                32'h504, m.tag + 1'b1, 1'b0);

        // Stalled rows hold the last unstalled result
        add_row(rows, m, exec_pkg::XOR, random_word(seed), random_word(seed), 32'h0,
                32'h600, m.tag, 1'b0);
        for (k = 0; k < 4; k++) begin
            add_row(rows, m, exec_pkg::exec_op_e'(int'(exec_pkg::SLT) + k), random_word(seed),
                    random_word(seed), 32'h0, 32'h604, m.tag, 1'b1);
        end
        add_row(rows, m, exec_pkg::AND, random_word(seed), random_word(seed), 32'h0,
                32'h608, m.tag, 1'b0);
    endfunction

endpackage

//--- dv/execute_tb.sv
// Testbench for the execute stage: applies the stimulus table to the DUT and checks every output
module execute_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_MARGIN = 20;

    logic                 clk;
    logic                 reset;
    logic                 stall_i;
    exec_tb_pkg::tag_t    tag_i;
    exec_pkg::exec_op_e   op_i;
    exec_pkg::word_t      first_operand_i;
    exec_pkg::word_t      second_operand_i;
    exec_pkg::word_t      third_operand_i;
    exec_pkg::word_t      pc_i;
    logic                 killed_o;
    logic                 jump_o;
    exec_pkg::word_t      jump_target_o;
    logic                 write_enable_o;
    exec_pkg::exec_op_e   op_o;
    exec_pkg::word_t      result_o;
    exec_pkg::word_t      mem_address_o;
    logic                 mem_read_enable_o;
    exec_pkg::byte_en_t   mem_write_enable_o;
    exec_pkg::word_t      mem_write_data_o;

    exec_tb_pkg::row_t    rows[$];
    integer               seed;
    int                   row_idx     = -1;
    int                   cycle_count = 0;
    int                   cycle_limit = 0;

    execute_top #(
        .TAG_WIDTH (exec_tb_pkg::TAG_WIDTH)
    ) DUT (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall_i),
        .tag_i              (tag_i),
        .op_i               (op_i),
        .first_operand_i    (first_operand_i),
        .second_operand_i   (second_operand_i),
        .third_operand_i    (third_operand_i),
        .pc_i               (pc_i),
        .killed_o           (killed_o),
        .jump_o             (jump_o),
        .jump_target_o      (jump_target_o),
        .write_enable_o     (write_enable_o),
        .op_o               (op_o),
        .result_o           (result_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t actual,
                              input exec_pkg::word_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h (row %0d)", name, actual, expected,
                     row_idx);
            abort_run();
        end
    endtask

    task automatic check_byte_en(input string name, input exec_pkg::byte_en_t actual,
                                 input exec_pkg::byte_en_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h (row %0d)", name, actual, expected,
                     row_idx);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input exec_pkg::exec_op_e actual,
                            input exec_pkg::exec_op_e expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h (row %0d)", name, actual, expected,
                     row_idx);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h (row %0d)", name, actual, expected,
                     row_idx);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////////////////////////////////////////

    // Non-jump, non-memory operation with the reset tag
    task automatic drive_idle();
        stall_i          <= 1'b0;
        tag_i            <= '0;
        op_i             <= exec_pkg::ADD;
        first_operand_i  <= '0;
        second_operand_i <= '0;
        third_operand_i  <= '0;
        pc_i             <= '0;
    endtask

    task automatic apply_row(input exec_tb_pkg::row_t r);
        stall_i          <= r.stall;
        tag_i            <= r.tag;
        op_i             <= r.op;
        first_operand_i  <= r.first;
        second_operand_i <= r.second;
        third_operand_i  <= r.third;
        pc_i             <= r.pc;
    endtask

    task automatic check_combinational(input exec_tb_pkg::row_t r);
        check_bit("killed_o", killed_o, r.killed);
        check_bit("jump_o", jump_o, r.jump);
        if (exec_tb_pkg::is_control(r.op)) begin
            check_word("jump_target_o", jump_target_o, r.target);
        end
        check_word("mem_address_o", mem_address_o, r.address);
        check_bit("mem_read_enable_o", mem_read_enable_o, r.read_en);
        check_byte_en("mem_write_enable_o", mem_write_enable_o, r.write_en);
        check_word("mem_write_data_o", mem_write_data_o, r.write_data);
    endtask

    task automatic check_registered(input exec_tb_pkg::row_t r);
        check_bit("write_enable_o", write_enable_o, r.we);
        check_op("op_o", op_o, r.op_out);
        check_word("result_o", result_o, r.result);
    endtask

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        seed = 32'hb96f;
        exec_tb_pkg::build_table(seed, rows);
        cycle_limit = rows.size() + RESET_CYCLES + TIMEOUT_MARGIN;
        reset <= 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // State right after reset
        @(negedge clk);
        check_bit("write_enable_o", write_enable_o, 1'b0);
        check_bit("jump_o", jump_o, 1'b0);
        check_bit("mem_read_enable_o", mem_read_enable_o, 1'b0);
        check_byte_en("mem_write_enable_o", mem_write_enable_o, 4'b0000);

        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            @(posedge clk);
            apply_row(rows[row_idx]);
            @(negedge clk);
            check_combinational(rows[row_idx]);
            if (row_idx > 0) begin
                check_registered(rows[row_idx - 1]);
            end
        end

        // Flush the last registered result
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_registered(rows[rows.size() - 1]);

        $display("sim passed");
        $finish;
    end

endmodule

//--- vlog.f
source/exec_pkg.sv
source/exec_operand_if.sv
source/exec_alu.sv
source/exec_branch.sv
source/exec_lsu.sv
source/execute_top.sv
dv/exec_tb_pkg.sv
dv/execute_tb.sv

//--- Bender.yml
package:
  name: execute_stage

sources:
  - files:
      - source/exec_pkg.sv
      - source/exec_operand_if.sv
      - source/exec_alu.sv
      - source/exec_branch.sv
      - source/exec_lsu.sv
      - source/execute_top.sv
  - target: test
    files:
      - dv/exec_tb_pkg.sv
      - dv/execute_tb.sv
